// File: src/cim_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, opcodes and bundles for the compute-in-memory macro.
// Row count follows row_addr_width; the bus address adds one select bit.
// Opcode values match the command words the host software emits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package cim_pkg;

    localparam int row_addr_width = 8;
    localparam int bus_addr_width = row_addr_width + 1;
    localparam int row_width      = 32;
    localparam int shift_width    = 5;
    localparam int row_count      = 1 << row_addr_width;

    // Port-B write data source
    localparam logic wr_sel_load   = 1'b0;
    localparam logic wr_sel_result = 1'b1;

    typedef logic [row_addr_width-1:0] row_addr_t;
    typedef logic [row_width-1:0]      row_data_t;

    typedef enum logic [7:0] {
        OP_MOVE  = 8'h01,
        OP_ORC   = 8'h03,
        OP_ANDC  = 8'h04,
        OP_XORC  = 8'h05,
        OP_LSHFT = 8'h08,
        OP_RSHFT = 8'h09,
        OP_P_INV = 8'h0E,
        OP_XNOR  = 8'h11
    } cim_op_e;

    // Command word layout, op in the top byte
    typedef struct packed {
        cim_op_e   op;
        row_addr_t s1;
        row_addr_t s2;
        row_addr_t d1;
    } cim_cmd_t;

    typedef enum logic [1:0] {
        REQ_LOAD,
        REQ_EXEC,
        REQ_READ
    } req_kind_e;

    typedef struct packed {
        req_kind_e kind;
        row_addr_t addr;
        row_data_t data;
    } cim_req_t;

    typedef enum logic [2:0] {
        BL_PASS,
        BL_INV,
        BL_OR,
        BL_AND,
        BL_XOR,
        BL_XNOR,
        BL_SHL,
        BL_SHR
    } bl_func_e;

    typedef struct packed {
        row_addr_t               addr_a;
        row_addr_t               addr_b;
        logic                    we_b;
        logic                    wr_sel;
        row_data_t               load_data;
        bl_func_e                func;
        logic [shift_width-1:0]  shift;
    } array_ctrl_t;

endpackage

// File: src/cim_bitline_logic.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational row operator behind the two array read ports.
// Shifts are logical with zero fill.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cim_bitline_logic (
    input  cim_pkg::bl_func_e                func,
    input  logic [cim_pkg::shift_width-1:0]  shift,
    input  cim_pkg::row_data_t               row_a,
    input  cim_pkg::row_data_t               row_b,
    output cim_pkg::row_data_t               result
);

    import cim_pkg::*;

    always_comb
    begin
        case (func)
            // Single-row functions on port A
            BL_PASS: result = row_a;
            BL_INV:  result = ~row_a;
            BL_SHL:  result = row_a << shift;
            BL_SHR:  result = row_a >> shift;

            // Two-row functions
            BL_OR:   result = row_a | row_b;
            BL_AND:  result = row_a & row_b;
            BL_XOR:  result = row_a ^ row_b;
            BL_XNOR: result = ~(row_a ^ row_b);
            default: result = row_a;
        endcase
    end

endmodule

// File: src/cim_row_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-port row memory, registered reads on both ports, no reset.
// Port B reads old data when it writes the same row in one cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cim_row_array (
    input  logic                  sys_clk_in,
    input  cim_pkg::array_ctrl_t  ctrl,
    input  cim_pkg::row_data_t    result,
    output cim_pkg::row_data_t    row_a,
    output cim_pkg::row_data_t    row_b
);

    import cim_pkg::*;

    row_data_t mem [row_count];
    row_data_t wdata_b;

    // Load data or the bitline result
    assign wdata_b = (ctrl.wr_sel == wr_sel_result) ? result : ctrl.load_data;

    // Port A is read only
    always_ff @(posedge sys_clk_in)
    begin
        row_a <= mem[ctrl.addr_a];
    end

    always_ff @(posedge sys_clk_in)
    begin
        row_b <= mem[ctrl.addr_b];
        if (ctrl.we_b)
            mem[ctrl.addr_b] <= wdata_b;
    end

endmodule

// File: src/cim_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Steps one request at a time through the row array.
// Load 2 cycles, row operation 4, read 3, unknown opcode 1 (to done).
// Single-row ops write s2, two-row ops write d1; shift uses d1[4:0].
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cim_sequencer (
    input  logic                  sys_clk_in,
    input  logic                  sys_reset_in,

    input  cim_pkg::cim_req_t     req,
    input  logic                  req_valid,
    output logic                  done,
    output cim_pkg::row_data_t    read_row,

    output cim_pkg::array_ctrl_t  ctrl,
    input  cim_pkg::row_data_t    row_a
);

    import cim_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_READ_WAIT,
        ST_READ_DONE,
        ST_OP_ADDR,
        ST_OP_READ,
        ST_OP_WRITE
    } seq_state_e;

    seq_state_e state;
    cim_cmd_t   cmd_in;
    cim_cmd_t   cmd;

    function automatic logic is_known(cim_op_e op);
        case (op)
            OP_MOVE, OP_P_INV, OP_LSHFT, OP_RSHFT,
            OP_ORC, OP_ANDC, OP_XORC, OP_XNOR: return 1'b1;
            default:                           return 1'b0;
        endcase
    endfunction

    // Two-row ops land in d1
    function automatic logic is_two_row(cim_op_e op);
        return (op == OP_ORC) || (op == OP_ANDC) || (op == OP_XORC) || (op == OP_XNOR);
    endfunction

    function automatic bl_func_e op_to_func(cim_op_e op);
        case (op)
            OP_P_INV: return BL_INV;
            OP_LSHFT: return BL_SHL;
            OP_RSHFT: return BL_SHR;
            OP_ORC:   return BL_OR;
            OP_ANDC:  return BL_AND;
            OP_XORC:  return BL_XOR;
            OP_XNOR:  return BL_XNOR;
            default:  return BL_PASS;
        endcase
    endfunction

    assign cmd_in = cim_cmd_t'(req.data);

    always_ff @(posedge sys_clk_in or posedge sys_reset_in)
    begin
        if (sys_reset_in)
        begin
            state <= ST_IDLE;
            done  <= 1'b0;
            ctrl  <= '0;
        end
        else
        begin
            done      <= 1'b0;
            ctrl.we_b <= 1'b0;

            case (state)
                ST_IDLE:
                begin
                    if (req_valid)
                    begin
                        case (req.kind)
                            REQ_LOAD:
                            begin
                                ctrl.addr_b    <= req.addr;
                                ctrl.we_b      <= 1'b1;
                                ctrl.wr_sel    <= wr_sel_load;
                                ctrl.load_data <= req.data;
                                state          <= ST_LOAD;
                            end
                            REQ_READ:
                            begin
                                ctrl.addr_a <= req.addr;
                                state       <= ST_READ_WAIT;
                            end
                            default:
                            begin
                                // Unknown opcodes retire right away
                                if (is_known(cmd_in.op))
                                    state <= ST_OP_ADDR;
                                else
                                    done  <= 1'b1;
                            end
                        endcase
                    end
                end

                ST_LOAD:
                begin
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end

                ST_READ_WAIT:
                    state <= ST_READ_DONE;

                ST_READ_DONE:
                begin
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end

                // Address phase, function and shift captured here
                ST_OP_ADDR:
                begin
                    ctrl.addr_a <= cmd.s1;
                    ctrl.addr_b <= cmd.s2;
                    ctrl.func   <= op_to_func(cmd.op);
                    ctrl.shift  <= cmd.d1[shift_width-1:0];
                    state       <= ST_OP_READ;
                end

                // Rows come out of the array this cycle
                ST_OP_READ:
                begin
                    ctrl.addr_b <= is_two_row(cmd.op) ? cmd.d1 : cmd.s2;
                    ctrl.we_b   <= 1'b1;
                    ctrl.wr_sel <= wr_sel_result;
                    state       <= ST_OP_WRITE;
                end

                ST_OP_WRITE:
                begin
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end

                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk_in)
    begin
        if (state == ST_IDLE && req_valid)
            cmd <= cmd_in;
        if (state == ST_READ_DONE)
            read_row <= row_a;
    end

endmodule

// File: src/cim_bus_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Avalon-MM slave front end. Only one request is in flight at a time.
// waitrequest stays high from acceptance until the sequencer retires it.
// Master must not raise write and read in the same cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cim_bus_port (
    input  logic                                sys_clk_in,
    input  logic                                sys_reset_in,

    input  logic [cim_pkg::bus_addr_width-1:0]  address,
    input  cim_pkg::row_data_t                  writedata,
    input  logic                                write,
    input  logic                                read,
    output logic                                waitrequest,
    output cim_pkg::row_data_t                  readdata,
    output logic                                readdatavalid,

    output cim_pkg::cim_req_t                   req,
    output logic                                req_valid,
    input  logic                                done,
    input  cim_pkg::row_data_t                  read_row
);

    import cim_pkg::*;

    logic      accept;
    logic      busy;
    req_kind_e kind_in;

    assign accept = (write | read) & ~waitrequest;

    // Top address bit picks a row load over a command
    always_comb
    begin
        if (read)
            kind_in = REQ_READ;
        else if (address[row_addr_width])
            kind_in = REQ_LOAD;
        else
            kind_in = REQ_EXEC;
    end

    always_ff @(posedge sys_clk_in or posedge sys_reset_in)
    begin
        if (sys_reset_in)
        begin
            waitrequest   <= 1'b1;
            busy          <= 1'b0;
            req_valid     <= 1'b0;
            readdatavalid <= 1'b0;
            req           <= '0;
        end
        else
        begin
            req_valid     <= accept;
            readdatavalid <= done & (req.kind == REQ_READ);

            // Held high through the whole operation
            busy          <= accept | (busy & ~done);
            waitrequest   <= accept | (busy & ~done);

            if (accept)
            begin
                req.kind <= kind_in;
                req.addr <= address[row_addr_width-1:0];
                req.data <= writedata;
            end
        end
    end

    // Read data held until the next read retires
    always_ff @(posedge sys_clk_in)
    begin
        if (done && req.kind == REQ_READ)
            readdata <= read_row;
    end

endmodule

// File: src/cim_macro_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compute-in-memory row macro behind one Avalon-MM slave port.
// Address bit 8 set loads a row; clear means the data is a command.
// Not pipelined: waitrequest covers each request until it retires.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module cim_macro_top (
    input  logic                                sys_clk_in,
    input  logic                                sys_reset_in,

    input  logic [cim_pkg::bus_addr_width-1:0]  address,
    input  cim_pkg::row_data_t                  writedata,
    input  logic                                write,
    input  logic                                read,
    output logic                                waitrequest,
    output cim_pkg::row_data_t                  readdata,
    output logic                                readdatavalid
);

    import cim_pkg::*;

    cim_req_t    req;
    logic        req_valid;
    logic        done;
    row_data_t   read_row;
    array_ctrl_t ctrl;
    row_data_t   row_a;
    row_data_t   row_b;
    row_data_t   result;

    cim_bus_port u_bus_port (
        .sys_clk_in    (sys_clk_in),
        .sys_reset_in  (sys_reset_in),
        .address       (address),
        .writedata     (writedata),
        .write         (write),
        .read          (read),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .readdatavalid (readdatavalid),
        .req           (req),
        .req_valid     (req_valid),
        .done          (done),
        .read_row      (read_row)
    );

    cim_sequencer u_sequencer (
        .sys_clk_in   (sys_clk_in),
        .sys_reset_in (sys_reset_in),
        .req          (req),
        .req_valid    (req_valid),
        .done         (done),
        .read_row     (read_row),
        .ctrl         (ctrl),
        .row_a        (row_a)
    );

    cim_row_array u_row_array (
        .sys_clk_in (sys_clk_in),
        .ctrl       (ctrl),
        .result     (result),
        .row_a      (row_a),
        .row_b      (row_b)
    );

    // Result feeds back into the port-B write data
    cim_bitline_logic u_bitline_logic (
        .func   (ctrl.func),
        .shift  (ctrl.shift),
        .row_a  (row_a),
        .row_b  (row_b),
        .result (result)
    );

endmodule

// File: bench/cim_test_table.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stimulus and expected rows for the CIM macro testbench.
// Included inside the testbench module after cim_pkg is imported.
// Columns: kind, rnd, use_model, row, data or command, expected row.
// rnd takes a load word or the shift amount in d1 from the LFSR.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CIM_TEST_TABLE_SVH
`define CIM_TEST_TABLE_SVH

typedef struct packed {
    req_kind_e kind;
    logic      rnd;
    logic      use_model;  // expected row taken from the model
    row_addr_t row;
    row_data_t data;
    row_data_t expected;
} test_rec_t;

localparam int test_count = 39;

localparam test_rec_t tests [test_count] = '{
    // Fixed rows through the two-row functions with d1 == s1 last
    '{REQ_LOAD, 1'b0, 1'b0, 8'h01, 32'hF0F0_1234, 32'h0},
    '{REQ_LOAD, 1'b0, 1'b0, 8'h02, 32'h0FF0_8421, 32'h0},
    '{REQ_READ, 1'b0, 1'b0, 8'h01, 32'h0, 32'hF0F0_1234},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_ORC, 8'h01, 8'h02, 8'h03}, 32'h0},
    '{REQ_READ, 1'b0, 1'b0, 8'h03, 32'h0, 32'hFFF0_9635},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_ANDC, 8'h01, 8'h02, 8'h04}, 32'h0},
    '{REQ_READ, 1'b0, 1'b0, 8'h04, 32'h0, 32'h00F0_0020},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_XORC, 8'h01, 8'h02, 8'h05}, 32'h0},
    '{REQ_READ, 1'b0, 1'b0, 8'h05, 32'h0, 32'hFF00_9615},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_XNOR, 8'h01, 8'h02, 8'h01}, 32'h0},
    '{REQ_READ, 1'b0, 1'b0, 8'h01, 32'h0, 32'h00FF_69EA},
    '{REQ_READ, 1'b0, 1'b0, 8'h02, 32'h0, 32'h0FF0_8421},
    // Shift edges with zero fill
    '{REQ_LOAD, 1'b0, 1'b0, 8'h40, 32'h8000_0001, 32'h0},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_LSHFT, 8'h40, 8'h41, 8'h01}, 32'h0},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_RSHFT, 8'h40, 8'h42, 8'h1F}, 32'h0},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_LSHFT, 8'h40, 8'h43, 8'h1F}, 32'h0},
    '{REQ_READ, 1'b0, 1'b0, 8'h41, 32'h0, 32'h0000_0002},
    '{REQ_READ, 1'b0, 1'b0, 8'h42, 32'h0, 32'h0000_0001},
    '{REQ_READ, 1'b0, 1'b0, 8'h43, 32'h0, 32'h8000_0000},
    '{REQ_READ, 1'b0, 1'b0, 8'h40, 32'h0, 32'h8000_0001},
    // Random rows written back to back under waitrequest
    '{REQ_LOAD, 1'b1, 1'b0, 8'h10, 32'h0, 32'h0},
    '{REQ_LOAD, 1'b1, 1'b0, 8'h11, 32'h0, 32'h0},
    '{REQ_READ, 1'b0, 1'b1, 8'h10, 32'h0, 32'h0},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_MOVE, 8'h10, 8'h20, 8'h00}, 32'h0},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_P_INV, 8'h10, 8'h21, 8'h00}, 32'h0},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_LSHFT, 8'h11, 8'h22, 8'h00}, 32'h0},
    '{REQ_EXEC, 1'b1, 1'b0, 8'h00, {OP_RSHFT, 8'h11, 8'h23, 8'h00}, 32'h0},
    '{REQ_EXEC, 1'b1, 1'b0, 8'h00, {OP_LSHFT, 8'h10, 8'h24, 8'h00}, 32'h0},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {8'h7F, 8'h20, 8'h21, 8'h22}, 32'h0},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_XORC, 8'h10, 8'h11, 8'h10}, 32'h0},
    '{REQ_EXEC, 1'b0, 1'b0, 8'h00, {OP_ORC, 8'h10, 8'h20, 8'h30}, 32'h0},
    '{REQ_READ, 1'b0, 1'b1, 8'h10, 32'h0, 32'h0},
    '{REQ_READ, 1'b0, 1'b1, 8'h11, 32'h0, 32'h0},
    '{REQ_READ, 1'b0, 1'b1, 8'h20, 32'h0, 32'h0},
    '{REQ_READ, 1'b0, 1'b1, 8'h21, 32'h0, 32'h0},
    '{REQ_READ, 1'b0, 1'b1, 8'h22, 32'h0, 32'h0},
    '{REQ_READ, 1'b0, 1'b1, 8'h23, 32'h0, 32'h0},
    '{REQ_READ, 1'b0, 1'b1, 8'h24, 32'h0, 32'h0},
    '{REQ_READ, 1'b0, 1'b1, 8'h30, 32'h0, 32'h0}
};

`endif

// File: bench/tb_cim_macro.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the CIM row macro, applies the table in cim_test_table.
// Inputs change 1 ns after the rising edge, outputs sampled on the fall.
// Reads only touch rows that earlier table entries have written.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module tb_cim_macro;

    import cim_pkg::*;

    `include "cim_test_table.svh"

    localparam int cycle_limit = test_count * 10 + 100;

    logic                      sys_clk_in;
    logic                      sys_reset_in;
    logic [bus_addr_width-1:0] address;
    row_data_t                 writedata;
    logic                      write;
    logic                      read;
    logic                      waitrequest;
    row_data_t                 readdata;
    logic                      readdatavalid;

    row_data_t   model [row_count];
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          reads_done;
    int          rdv_count;
    int          cycle_count;

    cim_macro_top uut (
        .sys_clk_in    (sys_clk_in),
        .sys_reset_in  (sys_reset_in),
        .address       (address),
        .writedata     (writedata),
        .write         (write),
        .read          (read),
        .waitrequest   (waitrequest),
        .readdata      (readdata),
        .readdatavalid (readdatavalid)
    );

    always #5 sys_clk_in = ~sys_clk_in;

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output row_data_t bits);
        bits = '0;
        for (int k = 0; k < n; k++)
        begin
            bits = {bits[row_width-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string what, input row_data_t got, input row_data_t want);
        checks++;
        assert (got === want)
        else
        begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", what, got, want);
            errors++;
        end
    endtask

    // Model of one command word
    task automatic apply_cmd(input row_data_t word);
        cim_cmd_t cmd;
        cmd = cim_cmd_t'(word);
        case (cmd.op)
            OP_MOVE:  model[cmd.s2] = model[cmd.s1];
            OP_P_INV: model[cmd.s2] = ~model[cmd.s1];
            OP_LSHFT: model[cmd.s2] = model[cmd.s1] << cmd.d1[shift_width-1:0];
            OP_RSHFT: model[cmd.s2] = model[cmd.s1] >> cmd.d1[shift_width-1:0];
            OP_ORC:   model[cmd.d1] = model[cmd.s1] | model[cmd.s2];
            OP_ANDC:  model[cmd.d1] = model[cmd.s1] & model[cmd.s2];
            OP_XORC:  model[cmd.d1] = model[cmd.s1] ^ model[cmd.s2];
            OP_XNOR:  model[cmd.d1] = ~(model[cmd.s1] ^ model[cmd.s2]);
            // Unknown opcodes leave every row alone
            default:  ;
        endcase
    endtask

    // Held until an edge sees waitrequest low, returns 1 ns after it
    task automatic issue_request(input logic rd, input logic [bus_addr_width-1:0] addr,
                                 input row_data_t data);
        address   = addr;
        writedata = data;
        write     = ~rd;
        read      = rd;
        @(negedge sys_clk_in);
        while (waitrequest)
            @(negedge sys_clk_in);
        @(posedge sys_clk_in);
        #1;
        write = 1'b0;
        read  = 1'b0;
    endtask

    task automatic fetch_row(input row_addr_t row, output row_data_t data);
        issue_request(1'b1, {1'b0, row}, '0);
        @(negedge sys_clk_in);
        while (waitrequest)
            @(negedge sys_clk_in);
        checks++;
        assert (readdatavalid === 1'b1)
        else
        begin
            $display("readdatavalid missing when waitrequest fell on read of row 0x%02h", row);
            errors++;
        end
        data = readdata;
        reads_done++;
        @(posedge sys_clk_in);
        #1;
    endtask

    always @(negedge sys_clk_in)
    begin
        if (readdatavalid === 1'b1)
            rdv_count++;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge sys_clk_in);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Testbench failed");
        $finish;
    end

    initial
    begin
        test_rec_t rec;
        row_data_t data;
        row_data_t bits;
        row_data_t got;
        int        settle;

        sys_clk_in   = 1'b0;
        sys_reset_in = 1'b1;
        address      = '0;
        writedata    = '0;
        write        = 1'b0;
        read         = 1'b0;
        lfsr         = 16'd27021;
        errors       = 0;
        checks       = 0;
        reads_done   = 0;
        rdv_count    = 0;

        repeat (2)
        begin
            @(posedge sys_clk_in);
            #1;
            check_value("waitrequest", row_data_t'(waitrequest), 32'h1);
            check_value("readdatavalid", row_data_t'(readdatavalid), 32'h0);
        end
        sys_reset_in = 1'b0;

        // Port opens within two cycles of release
        settle = 0;
        while (waitrequest && settle < 2)
        begin
            @(negedge sys_clk_in);
            settle++;
        end
        check_value("waitrequest", row_data_t'(waitrequest), 32'h0);
        @(posedge sys_clk_in);
        #1;

        for (int i = 0; i < test_count; i++)
        begin
            rec  = tests[i];
            data = rec.data;
            if (rec.rnd && rec.kind == REQ_LOAD)
            begin
                random_bits(row_width, data);
            end
            else if (rec.rnd)
            begin
                random_bits(shift_width, bits);
                data[shift_width-1:0] = bits[shift_width-1:0];
            end

            case (rec.kind)
                REQ_LOAD:
                begin
                    issue_request(1'b0, {1'b1, rec.row}, data);
                    model[rec.row] = data;
                end
                REQ_EXEC:
                begin
                    issue_request(1'b0, {1'b0, rec.row}, data);
                    apply_cmd(data);
                end
                default:
                begin
                    fetch_row(rec.row, got);
                    check_value($sformatf("readdata row 0x%02h", rec.row), got,
                                rec.use_model ? model[rec.row] : rec.expected);
                end
            endcase
        end

        checks++;
        assert (rdv_count == reads_done)
        else
        begin
            $display("readdatavalid pulsed %0d times for %0d reads", rdv_count, reads_done);
            errors++;
        end

        $display("Checks: %0d, errors: %0d, reads: %0d", checks, errors, reads_done);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: cim_macro.f
+incdir+bench
src/cim_pkg.sv
src/cim_bitline_logic.sv
src/cim_row_array.sv
src/cim_sequencer.sv
src/cim_bus_port.sv
src/cim_macro_top.sv
bench/tb_cim_macro.sv

// File: run_sim.sh
#!/bin/sh
# Builds the CIM macro testbench with Verilator, runs it, and checks the log
rm -f sim.log && \
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_cim_macro -f cim_macro.f && \
./obj_dir/Vtb_cim_macro > sim.log 2>&1
grep -qx "Testbench passed" sim.log \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail, see sim.log"; exit 1; }
